// ==== compile.f ====
hdl/cpu_pkg.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/core_ctrl.sv
hdl/cpu_top.sv
verif/tb_cpu.sv

// ==== hdl/core_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_ctrl #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::word_t     wb_rdata,
    input  logic               wb_ack,
    input  cpu_pkg::word_t     alu_res,
    input  cpu_pkg::word_t     npc,
    input  cpu_pkg::word_t     rs2_data,
    input  cpu_pkg::reg_addr_t rd,
    input  logic               rd_we,
    input  cpu_pkg::wd_sel_e   wd_sel,
    input  logic               is_load,
    input  logic               is_store,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output cpu_pkg::word_t     wb_adr,
    output cpu_pkg::word_t     wb_wdata,
    output cpu_pkg::word_t     pc,
    output cpu_pkg::word_t     inst,
    output logic               rf_we,
    output cpu_pkg::reg_addr_t rf_wa,
    output cpu_pkg::word_t     rf_wd,
    output logic               commit,
    output cpu_pkg::word_t     commit_pc,
    output cpu_pkg::word_t     commit_inst,
    output logic               commit_halt,
    output logic               commit_reg_we,
    output cpu_pkg::reg_addr_t commit_reg_wa,
    output cpu_pkg::word_t     commit_reg_wd,
    output logic               commit_dmem_we,
    output cpu_pkg::word_t     commit_dmem_wa,
    output cpu_pkg::word_t     commit_dmem_wd
);

    typedef enum logic [2:0] {FETCH, EXEC, MEM, WB, HALTED} state_e;

    state_e         state;
    cpu_pkg::word_t alu_q;
    cpu_pkg::word_t npc_q;
    cpu_pkg::word_t ld_data;
    logic           is_halt;
    logic           bus_done;

    assign is_halt  = (inst == cpu_pkg::HALT_INST);
    assign bus_done = wb_cyc && wb_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= FETCH;
            pc     <= RESET_PC;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (!wb_cyc) begin     // Start the fetch cycle
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= 1'b0;
                        wb_adr <= pc;
                    end else if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        inst   <= wb_rdata;
                        state  <= EXEC;
                    end
                end
                EXEC: begin
                    alu_q    <= alu_res;
                    npc_q    <= npc;
                    wb_wdata <= rs2_data;
                    if (is_load || is_store) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= is_store;
                        wb_adr <= alu_res;
                        state  <= MEM;
                    end else begin
                        state <= WB;
                    end
                end
                MEM: begin
                    if (bus_done) begin
                        wb_cyc  <= 1'b0;
                        wb_stb  <= 1'b0;
                        wb_we   <= 1'b0;
                        ld_data <= wb_rdata;
                        state   <= WB;
                    end
                end
                WB: begin
                    pc    <= npc_q;
                    state <= is_halt ? HALTED : FETCH;
                end
                default: ;     // HALTED until reset
            endcase
        end
    end

    assign rf_we = (state == WB) && rd_we;
    assign rf_wa = rd;

    always_comb begin
        case (wd_sel)
            cpu_pkg::WD_PC4: rf_wd = pc + 32'd4;
            cpu_pkg::WD_MEM: rf_wd = ld_data;
            default:         rf_wd = alu_q;
        endcase
    end

    // Commit trace registered one cycle after WB
    always_ff @(posedge clk) begin
        if (rst) begin
            commit         <= 1'b0;
            commit_halt    <= 1'b0;
            commit_reg_we  <= 1'b0;
            commit_dmem_we <= 1'b0;
        end else begin
            commit         <= (state == WB);
            commit_halt    <= (state == WB) && is_halt;
            commit_reg_we  <= rf_we;
            commit_dmem_we <= (state == WB) && is_store;
        end
    end

    always_ff @(posedge clk) begin
        if (state == WB) begin
            commit_pc      <= pc;
            commit_inst    <= inst;
            commit_reg_wa  <= rf_wa;
            commit_reg_wd  <= rf_wd;
            commit_dmem_wa <= alu_q;
            commit_dmem_wd <= wb_wdata;
        end
    end

    // Bus released after every ack
    a_cyc_drop: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && wb_ack) |=> !wb_cyc);

    // Request held until acknowledged
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_wdata)));

endmodule

`default_nettype wire

// ==== hdl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    parameter int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;     // Data, address or instruction
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ   = 2'd1,
        BR_NE   = 2'd2,
        BR_JAL  = 2'd3
    } br_type_e;

    // Writeback source
    typedef enum logic [1:0] {
        WD_PC4 = 2'd0,
        WD_ALU = 2'd1,
        WD_MEM = 2'd2
    } wd_sel_e;

    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_OPIMM  = 7'b0010011;
    parameter logic [6:0] OPC_LOAD   = 7'b0000011;
    parameter logic [6:0] OPC_STORE  = 7'b0100011;
    parameter logic [6:0] OPC_BRANCH = 7'b1100011;
    parameter logic [6:0] OPC_JAL    = 7'b1101111;

    // Decodes as unknown, so it writes nothing
    parameter word_t HALT_INST = 32'h80000000;

endpackage

`default_nettype wire

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::word_t     wb_rdata,
    input  logic               wb_ack,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output cpu_pkg::word_t     wb_adr,
    output cpu_pkg::word_t     wb_wdata,
    output logic               commit,
    output cpu_pkg::word_t     commit_pc,
    output cpu_pkg::word_t     commit_inst,
    output logic               commit_halt,
    output logic               commit_reg_we,
    output cpu_pkg::reg_addr_t commit_reg_wa,
    output cpu_pkg::word_t     commit_reg_wd,
    output logic               commit_dmem_we,
    output cpu_pkg::word_t     commit_dmem_wa,
    output cpu_pkg::word_t     commit_dmem_wd
);

    cpu_pkg::word_t     pc;
    cpu_pkg::word_t     inst;
    cpu_pkg::alu_op_e   alu_op;
    cpu_pkg::br_type_e  br_type;
    cpu_pkg::wd_sel_e   wd_sel;
    cpu_pkg::word_t     imm;
    cpu_pkg::reg_addr_t rs1;
    cpu_pkg::reg_addr_t rs2;
    cpu_pkg::reg_addr_t rd;
    logic               rd_we;
    logic               src1_imm;
    logic               src0_pc;
    logic               is_load;
    logic               is_store;
    cpu_pkg::word_t     rs1_data;
    cpu_pkg::word_t     rs2_data;
    cpu_pkg::word_t     alu_res;
    cpu_pkg::word_t     npc;
    logic               rf_we;
    cpu_pkg::reg_addr_t rf_wa;
    cpu_pkg::word_t     rf_wd;

    decoder i_decoder (
        .inst     (inst),
        .alu_op   (alu_op),
        .br_type  (br_type),
        .wd_sel   (wd_sel),
        .imm      (imm),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .rd_we    (rd_we),
        .src1_imm (src1_imm),
        .src0_pc  (src0_pc),
        .is_load  (is_load),
        .is_store (is_store)
    );

    reg_file i_reg_file (
        .clk (clk),
        .rs1 (rs1),
        .rs2 (rs2),
        .wa  (rf_wa),
        .we  (rf_we),
        .wd  (rf_wd),
        .rd0 (rs1_data),
        .rd1 (rs2_data)
    );

    exec_unit i_exec_unit (
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .alu_op   (alu_op),
        .br_type  (br_type),
        .src0_pc  (src0_pc),
        .src1_imm (src1_imm),
        .alu_res  (alu_res),
        .npc      (npc)
    );

    core_ctrl #(
        .RESET_PC (RESET_PC)
    ) i_core_ctrl (
        .clk            (clk),
        .rst            (rst),
        .wb_rdata       (wb_rdata),
        .wb_ack         (wb_ack),
        .alu_res        (alu_res),
        .npc            (npc),
        .rs2_data       (rs2_data),
        .rd             (rd),
        .rd_we          (rd_we),
        .wd_sel         (wd_sel),
        .is_load        (is_load),
        .is_store       (is_store),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_wdata       (wb_wdata),
        .pc             (pc),
        .inst           (inst),
        .rf_we          (rf_we),
        .rf_wa          (rf_wa),
        .rf_wd          (rf_wd),
        .commit         (commit),
        .commit_pc      (commit_pc),
        .commit_inst    (commit_inst),
        .commit_halt    (commit_halt),
        .commit_reg_we  (commit_reg_we),
        .commit_reg_wa  (commit_reg_wa),
        .commit_reg_wd  (commit_reg_wd),
        .commit_dmem_we (commit_dmem_we),
        .commit_dmem_wa (commit_dmem_wa),
        .commit_dmem_wd (commit_dmem_wd)
    );

endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  cpu_pkg::word_t     inst,
    output cpu_pkg::alu_op_e   alu_op,
    output cpu_pkg::br_type_e  br_type,
    output cpu_pkg::wd_sel_e   wd_sel,
    output cpu_pkg::word_t     imm,
    output cpu_pkg::reg_addr_t rs1,
    output cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::reg_addr_t rd,
    output logic               rd_we,
    output logic               src1_imm,
    output logic               src0_pc,
    output logic               is_load,
    output logic               is_store
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       wr_en;     // Write intent before the x0 check

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    always_comb begin
        alu_op   = cpu_pkg::ALU_ADD;
        br_type  = cpu_pkg::BR_NONE;
        wd_sel   = cpu_pkg::WD_ALU;
        imm      = {{20{inst[31]}}, inst[31:20]};     // I format
        wr_en    = 1'b0;
        src1_imm = 1'b0;
        src0_pc  = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (opcode)
            cpu_pkg::OPC_OP: begin
                wr_en = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = cpu_pkg::ALU_ADD;
                    10'b0100000_000: alu_op = cpu_pkg::ALU_SUB;
                    10'b0000000_111: alu_op = cpu_pkg::ALU_AND;
                    10'b0000000_110: alu_op = cpu_pkg::ALU_OR;
                    10'b0000000_100: alu_op = cpu_pkg::ALU_XOR;
                    10'b0000000_010: alu_op = cpu_pkg::ALU_SLT;
                    default:         wr_en  = 1'b0;
                endcase
            end
            cpu_pkg::OPC_OPIMM: begin
                wr_en    = (funct3 == 3'b000);     // ADDI only
                src1_imm = 1'b1;
            end
            cpu_pkg::OPC_LOAD: begin
                is_load  = (funct3 == 3'b010);
                wr_en    = (funct3 == 3'b010);
                src1_imm = 1'b1;
                wd_sel   = cpu_pkg::WD_MEM;
            end
            cpu_pkg::OPC_STORE: begin
                is_store = (funct3 == 3'b010);
                src1_imm = 1'b1;
                imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            cpu_pkg::OPC_BRANCH: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                if (funct3 == 3'b000) begin
                    br_type = cpu_pkg::BR_EQ;
                end else if (funct3 == 3'b001) begin
                    br_type = cpu_pkg::BR_NE;
                end
            end
            cpu_pkg::OPC_JAL: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                br_type  = cpu_pkg::BR_JAL;
                wd_sel   = cpu_pkg::WD_PC4;     // Link value
                wr_en    = 1'b1;
                src0_pc  = 1'b1;
                src1_imm = 1'b1;
            end
            default: ;
        endcase
    end

    assign rd_we = wr_en && (rd != '0);

endmodule

`default_nettype wire

// ==== hdl/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  cpu_pkg::word_t    pc,
    input  cpu_pkg::word_t    rs1_data,
    input  cpu_pkg::word_t    rs2_data,
    input  cpu_pkg::word_t    imm,
    input  cpu_pkg::alu_op_e  alu_op,
    input  cpu_pkg::br_type_e br_type,
    input  logic              src0_pc,
    input  logic              src1_imm,
    output cpu_pkg::word_t    alu_res,
    output cpu_pkg::word_t    npc
);

    cpu_pkg::word_t op_a;
    cpu_pkg::word_t op_b;
    logic           taken;

    assign op_a = src0_pc ? pc : rs1_data;
    assign op_b = src1_imm ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD: alu_res = op_a + op_b;
            cpu_pkg::ALU_SUB: alu_res = op_a - op_b;
            cpu_pkg::ALU_AND: alu_res = op_a & op_b;
            cpu_pkg::ALU_OR:  alu_res = op_a | op_b;
            cpu_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            cpu_pkg::ALU_SLT: begin
                alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            default:          alu_res = op_a + op_b;
        endcase
    end

    // Branch compare always uses the raw register values
    always_comb begin
        case (br_type)
            cpu_pkg::BR_EQ:  taken = (rs1_data == rs2_data);
            cpu_pkg::BR_NE:  taken = (rs1_data != rs2_data);
            cpu_pkg::BR_JAL: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign npc = taken ? (pc + imm) : (pc + 32'd4);

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    input  cpu_pkg::reg_addr_t wa,
    input  logic               we,
    input  cpu_pkg::word_t     wd,
    output cpu_pkg::word_t     rd0,
    output cpu_pkg::word_t     rd1
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[wa] <= wd;
        end
    end

    // x0 is hardwired
    assign rd0 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd1 = (rs2 == '0) ? '0 : regs[rs2];

    // The decoder must have filtered writes to x0 before they reach here
    a_no_x0_write: assert property (@(posedge clk) !(we && (wa == '0)));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run the testbench, then scan the log
verilator --binary --timing --assert --top-module tb_cpu -f compile.f > build.log 2>&1 \
    || { cat build.log; exit 1; }
./obj_dir/Vtb_cpu > sim.log 2>&1 && cat sim.log || { cat sim.log; exit 1; }
grep -q "Checks failed" sim.log && exit 1 || exit 0

// ==== verif/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam cpu_pkg::word_t start_pc = 32'h0000_0100;
    localparam int clk_period   = 20;
    localparam int reset_cycles = 10;
    localparam int n_rand       = 40;     // Random ALU instructions
    localparam int quiet_cycles = 50;     // Observed after the halt commits

    logic               clk;
    logic               rst = 1'b1;
    cpu_pkg::word_t     wb_rdata = '0;
    logic               wb_ack = 1'b0;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    cpu_pkg::word_t     wb_adr;
    cpu_pkg::word_t     wb_wdata;
    logic               commit;
    cpu_pkg::word_t     commit_pc;
    cpu_pkg::word_t     commit_inst;
    logic               commit_halt;
    logic               commit_reg_we;
    cpu_pkg::reg_addr_t commit_reg_wa;
    cpu_pkg::word_t     commit_reg_wd;
    logic               commit_dmem_we;
    cpu_pkg::word_t     commit_dmem_wa;
    cpu_pkg::word_t     commit_dmem_wd;

    cpu_pkg::word_t     mem [1024];       // Word-addressed bus memory
    cpu_pkg::word_t     ref_mem [1024];   // Model copy
    cpu_pkg::word_t     ref_regs [32];
    cpu_pkg::word_t     ref_pc;
    logic [31:0]        rng = 32'h2e2e9565;
    logic [9:0]         load_idx;
    logic               built = 1'b0;
    logic               halt_seen = 1'b0;
    int                 prog_len = 0;
    int                 errors = 0;
    int                 n_commits = 0;

    cpu_pkg::word_t     exp_pc;
    cpu_pkg::word_t     exp_inst;
    logic               exp_halt;
    logic               exp_reg_we;
    cpu_pkg::reg_addr_t exp_reg_wa;
    cpu_pkg::word_t     exp_reg_wd;
    logic               exp_dmem_we;
    cpu_pkg::word_t     exp_dmem_wa;
    cpu_pkg::word_t     exp_dmem_wd;

    cpu_top #(
        .RESET_PC (start_pc)
    ) i_dut (
        .clk            (clk),
        .rst            (rst),
        .wb_rdata       (wb_rdata),
        .wb_ack         (wb_ack),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_wdata       (wb_wdata),
        .commit         (commit),
        .commit_pc      (commit_pc),
        .commit_inst    (commit_inst),
        .commit_halt    (commit_halt),
        .commit_reg_we  (commit_reg_we),
        .commit_reg_wa  (commit_reg_wa),
        .commit_reg_wd  (commit_reg_wd),
        .commit_dmem_we (commit_dmem_we),
        .commit_dmem_wa (commit_dmem_wa),
        .commit_dmem_wd (commit_dmem_wd)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // RV32I instruction encoders
    function automatic cpu_pkg::word_t enc_r(input logic [6:0] f7, input cpu_pkg::reg_addr_t rs2,
            input cpu_pkg::reg_addr_t rs1, input logic [2:0] f3, input cpu_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, cpu_pkg::OPC_OP};
    endfunction

    function automatic cpu_pkg::word_t enc_i(input logic [11:0] imm, input cpu_pkg::reg_addr_t rs1,
            input logic [2:0] f3, input cpu_pkg::reg_addr_t rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic cpu_pkg::word_t enc_s(input logic [11:0] imm, input cpu_pkg::reg_addr_t rs2,
            input cpu_pkg::reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::OPC_STORE};
    endfunction

    function automatic cpu_pkg::word_t enc_b(input logic [12:0] imm, input cpu_pkg::reg_addr_t rs2,
            input cpu_pkg::reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::OPC_BRANCH};
    endfunction

    function automatic cpu_pkg::word_t enc_j(input logic [20:0] imm, input cpu_pkg::reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpu_pkg::OPC_JAL};
    endfunction

    task automatic emit(input cpu_pkg::word_t w);
        mem[load_idx] = w;
        load_idx = load_idx + 10'd1;
        prog_len++;
    endtask

    task automatic build_program;
        logic [31:0] r;
        cpu_pkg::reg_addr_t rd;
        for (int k = 0; k < 1024; k++) begin
            mem[10'(k)] = (cpu_pkg::word_t'(k * 4) * 32'h9e3779b1) ^ 32'h5a5a5a5a;
        end
        load_idx = start_pc[11:2];
        emit(enc_i(12'h123, 5'd0, 3'd0, 5'd1, cpu_pkg::OPC_OPIMM));
        emit(enc_i(12'hfaa, 5'd0, 3'd0, 5'd2, cpu_pkg::OPC_OPIMM));
        emit(enc_i(12'h007, 5'd0, 3'd0, 5'd3, cpu_pkg::OPC_OPIMM));
        emit(enc_i(12'hfff, 5'd0, 3'd0, 5'd4, cpu_pkg::OPC_OPIMM));
        emit(enc_i(12'h7ff, 5'd0, 3'd0, 5'd5, cpu_pkg::OPC_OPIMM));
        emit(enc_i(12'h000, 5'd0, 3'd0, 5'd6, cpu_pkg::OPC_OPIMM));
        emit(enc_i(12'h400, 5'd0, 3'd0, 5'd7, cpu_pkg::OPC_OPIMM));     // Data base
        emit(enc_s(12'd0, 5'd1, 5'd7));
        emit(enc_s(12'd8, 5'd2, 5'd7));
        emit(enc_i(12'd0, 5'd7, 3'b010, 5'd3, cpu_pkg::OPC_LOAD));
        emit(enc_i(12'd8, 5'd7, 3'b010, 5'd4, cpu_pkg::OPC_LOAD));
        emit(enc_i(12'd4, 5'd7, 3'b010, 5'd5, cpu_pkg::OPC_LOAD));     // Fill data
        emit(enc_b(13'd8, 5'd1, 5'd3, 3'd0));     // Taken
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd6, cpu_pkg::OPC_OPIMM));
        emit(enc_b(13'd8, 5'd1, 5'd3, 3'd1));     // Not taken
        emit(enc_b(13'd8, 5'd1, 5'd4, 3'd1));
        emit(enc_i(12'd2, 5'd0, 3'd0, 5'd6, cpu_pkg::OPC_OPIMM));
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'd0));
        emit(enc_j(21'd8, 5'd6));                 // Link into x6
        emit(enc_i(12'd3, 5'd0, 3'd0, 5'd5, cpu_pkg::OPC_OPIMM));
        emit(enc_j(21'd8, 5'd0));
        emit(enc_i(12'd4, 5'd0, 3'd0, 5'd5, cpu_pkg::OPC_OPIMM));
        emit(32'hffff_ffff);                      // Unknown opcode
        emit(enc_i(12'd5, 5'd1, 3'd0, 5'd0, cpu_pkg::OPC_OPIMM));
        for (int k = 0; k < n_rand; k++) begin
            rng = xorshift(rng);
            r = rng;
            rd = (k % 10 == 3) ? 5'd0 : {2'b00, r[2:0]};
            case (r[11:9])
                3'd0:    emit(enc_r(7'h00, {2'b00, r[8:6]}, {2'b00, r[5:3]}, 3'd0, rd));
                3'd1:    emit(enc_r(7'h20, {2'b00, r[8:6]}, {2'b00, r[5:3]}, 3'd0, rd));
                3'd2:    emit(enc_r(7'h00, {2'b00, r[8:6]}, {2'b00, r[5:3]}, 3'd7, rd));
                3'd3:    emit(enc_r(7'h00, {2'b00, r[8:6]}, {2'b00, r[5:3]}, 3'd6, rd));
                3'd4:    emit(enc_r(7'h00, {2'b00, r[8:6]}, {2'b00, r[5:3]}, 3'd4, rd));
                3'd5:    emit(enc_r(7'h00, {2'b00, r[8:6]}, {2'b00, r[5:3]}, 3'd2, rd));
                default: emit(enc_i(r[31:20], {2'b00, r[5:3]}, 3'd0, rd, cpu_pkg::OPC_OPIMM));
            endcase
        end
        emit(cpu_pkg::HALT_INST);
    endtask

    // Instruction-set model stepping one instruction per call
    function automatic void ref_step();
        cpu_pkg::word_t w;
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t addr;
        cpu_pkg::word_t next;
        cpu_pkg::reg_addr_t rd;
        w = ref_mem[ref_pc[11:2]];
        rd = w[11:7];
        a = ref_regs[w[19:15]];
        b = ref_regs[w[24:20]];
        next = ref_pc + 32'd4;
        exp_pc = ref_pc;
        exp_inst = w;
        exp_halt = (w == cpu_pkg::HALT_INST);
        exp_reg_we = 1'b0;
        exp_reg_wa = rd;
        exp_reg_wd = '0;
        exp_dmem_we = 1'b0;
        exp_dmem_wa = '0;
        exp_dmem_wd = '0;
        case (w[6:0])
            cpu_pkg::OPC_OP: begin
                exp_reg_we = 1'b1;
                case ({w[31:25], w[14:12]})
                    10'h000: exp_reg_wd = a + b;
                    10'h100: exp_reg_wd = a - b;
                    10'h007: exp_reg_wd = a & b;
                    10'h006: exp_reg_wd = a | b;
                    10'h004: exp_reg_wd = a ^ b;
                    10'h002: exp_reg_wd = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: exp_reg_we = 1'b0;
                endcase
            end
            cpu_pkg::OPC_OPIMM: begin
                exp_reg_we = (w[14:12] == 3'd0);
                exp_reg_wd = a + {{20{w[31]}}, w[31:20]};
            end
            cpu_pkg::OPC_LOAD: begin
                addr = a + {{20{w[31]}}, w[31:20]};
                exp_reg_we = (w[14:12] == 3'b010);
                exp_reg_wd = ref_mem[addr[11:2]];
            end
            cpu_pkg::OPC_STORE: begin
                if (w[14:12] == 3'b010) begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    exp_dmem_we = 1'b1;
                    exp_dmem_wa = addr;
                    exp_dmem_wd = b;
                    ref_mem[addr[11:2]] = b;
                end
            end
            cpu_pkg::OPC_BRANCH: begin
                if ((w[14:12] == 3'd0 && a == b) || (w[14:12] == 3'd1 && a != b)) begin
                    next = ref_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            cpu_pkg::OPC_JAL: begin
                exp_reg_we = 1'b1;
                exp_reg_wd = ref_pc + 32'd4;
                next = ref_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            default: ;
        endcase
        if (rd == 5'd0) begin
            exp_reg_we = 1'b0;
        end
        if (exp_reg_we) begin
            ref_regs[rd] = exp_reg_wd;
        end
        ref_pc = next;
    endfunction

    task automatic check_val(input string name, input cpu_pkg::word_t got,
            input cpu_pkg::word_t expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic compare_commit;
        if (halt_seen) begin
            $display("A commit appeared at %0t after the halt had committed", $time);
            errors++;
        end else begin
            ref_step();
            n_commits++;
            check_val("commit_pc", commit_pc, exp_pc);
            check_val("commit_inst", commit_inst, exp_inst);
            check_val("commit_halt", 32'(commit_halt), 32'(exp_halt));
            check_val("commit_reg_we", 32'(commit_reg_we), 32'(exp_reg_we));
            check_val("commit_dmem_we", 32'(commit_dmem_we), 32'(exp_dmem_we));
            if (exp_reg_we) begin
                check_val("commit_reg_wa", 32'(commit_reg_wa), 32'(exp_reg_wa));
                check_val("commit_reg_wd", commit_reg_wd, exp_reg_wd);
            end
            if (exp_dmem_we) begin
                check_val("commit_dmem_wa", commit_dmem_wa, exp_dmem_wa);
                check_val("commit_dmem_wd", commit_dmem_wd, exp_dmem_wd);
            end
            halt_seen = exp_halt || commit_halt;
        end
    endtask

    // Memory model answering each Wishbone cycle after 0 to 3 cycles
    initial begin
        int wait_left;
        logic [9:0] idx;
        wait_left = -1;
        build_program();
        built = 1'b1;
        forever begin
            @(negedge clk);
            if (wb_ack) begin
                wb_ack = 1'b0;     // Cycle closed at the ack edge
            end else if (!rst && wb_cyc && wb_stb) begin
                if (wait_left < 0) begin
                    rng = xorshift(rng);
                    wait_left = int'(rng[1:0]);
                end
                if (wait_left == 0) begin
                    idx = wb_adr[11:2];
                    wb_rdata = mem[idx];
                    if (wb_we) begin
                        mem[idx] = wb_wdata;
                    end
                    wb_ack = 1'b1;
                end
                wait_left = wait_left - 1;
            end
        end
    end

    initial begin
        int limit;
        wait (built);
        limit = prog_len * 12 * clk_period + (reset_cycles + quiet_cycles) * clk_period;
        #(limit);
        $display("Timeout: the run did not finish within %0d ns", limit);
        $display("Checks failed");
        $finish;
    end

    initial begin
        wait (built);
        ref_mem = mem;
        ref_pc = start_pc;
        for (int k = 0; k < 32; k++) begin
            ref_regs[k] = '0;
        end
        repeat (reset_cycles) begin
            @(negedge clk);
            check_val("wb_cyc", 32'(wb_cyc), 32'h0);
            check_val("commit", 32'(commit), 32'h0);
        end
        rst = 1'b0;
        @(negedge clk);
        check_val("wb_cyc", 32'(wb_cyc), 32'h1);     // First fetch right after reset
        check_val("wb_stb", 32'(wb_stb), 32'h1);
        check_val("wb_adr", wb_adr, start_pc);
        check_val("wb_we", 32'(wb_we), 32'h0);
        fork
            forever begin
                @(negedge clk);
                if (commit) begin
                    compare_commit();
                end
            end
        join_none
        wait (halt_seen);
        repeat (quiet_cycles) begin
            @(negedge clk);
            check_val("commit", 32'(commit), 32'h0);
            check_val("wb_cyc", 32'(wb_cyc), 32'h0);
            check_val("wb_stb", 32'(wb_stb), 32'h0);
        end
        $display("Errors: %0d, commits checked: %0d", errors, n_commits);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
